// ==== stripe_top.f ====
+incdir+source
source/stripe_pkg.sv
source/stripe_config.sv
source/stripe_bank.sv
source/stripe_router.sv
source/stripe_writer.sv
source/stripe_top.sv
testbench/stripe_assert.sv
testbench/stripe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the striped write path with Verilator and runs the testbench
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module stripe_tb -f stripe_top.f -o stripe_sim

# Assertion failures may end the run early, so the search below decides the result
output=$(./obj_dir/stripe_sim +verilator+error+limit+1000) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "NO ERRORS"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1

// ==== testbench/stripe_tb.sv ====
`include "stripe_macros.svh"

module stripe_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import stripe_pkg::*;

  typedef logic [`STRIPE_DATA_WIDTH-1:0] word_t;
  typedef logic [`STRIPE_STRB_WIDTH-1:0] strb_t;
  typedef logic [`STRIPE_DELAY_WIDTH-1:0] delay_t;

  localparam logic [1:0] okay_code = 2'b00;
  localparam logic [1:0] slverr_code = 2'b10;
  localparam int max_delay = (1 << `STRIPE_DELAY_WIDTH) - 1;
  localparam int max_strb = (1 << `STRIPE_STRB_WIDTH) - 1;
  // Writes per test: striping 8, ordering 2, in-order 4, protection 4, back-pressure 12
  localparam int timeout_cycles = (8 + 2 + 4 + 4 + 12) * (max_delay + 4) + 600;

  logic         axi_clk = 1'b0;
  logic         reset = 1'b1;
  logic         awvalid = 1'b0;
  aw_chan_t     aw = '0;
  logic         wvalid = 1'b0;
  w_chan_t      w = '0;
  logic         bready = 1'b1;
  cfg_write_t   cfg = '0;
  logic         rd_en = 1'b0;
  stripe_addr_u rd_addr = '0;
  logic         awready;
  logic         wready;
  logic         bvalid;
  b_chan_t      b;
  logic         rd_valid;
  word_t        rd_data;

  word_t      ref_mem [32];
  logic       cfg_protect [`STRIPE_NUM_S];
  logic [1:0] exp_resp [$];
  logic [1:0] exp_head;
  logic       stall_bready = 1'b0;
  int         stall_left = 0;
  int         errors = 0;
  int         checks = 0;
  int         writes_issued = 0;
  int         b_count = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         test_start_errors = 0;
  int         cycle_count = 0;

  stripe_top DUT (.*);

  always #2ns axi_clk = ~axi_clk;

  always @(posedge axi_clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout after %0d cycles, a handshake never completed", cycle_count);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // Random stretches of bready low while stalling is switched on
  always @(posedge axi_clk) begin
    #0.5ns;
    if (!stall_bready) begin
      bready = 1'b1;
    end else if (stall_left > 0) begin
      stall_left--;
      bready = 1'b0;
    end else if ($urandom_range(0, 3) == 0) begin
      stall_left = $urandom_range(0, 3);
      bready = 1'b0;
    end else begin
      bready = 1'b1;
    end
  end

  // Every B transfer must match the oldest expected response
  always @(negedge axi_clk) begin
    if (!reset && bvalid && bready) begin
      checks++;
      b_count++;
      if (exp_resp.size() == 0) begin
        errors++;
        $display("B response at %0t while no write was outstanding", $time);
      end else begin
        exp_head = exp_resp.pop_front();
        if (b.resp !== exp_head) report_mismatch("b.resp", word_t'(exp_head), word_t'(b.resp));
      end
    end
  end

  function automatic int total_errors();
    return errors + DUT.stripe_assert_i.fail_count;
  endfunction

  function automatic logic [`STRIPE_ADDR_WIDTH-1:0] byte_addr(input int word);
    return (`STRIPE_ADDR_WIDTH)'(word * `STRIPE_STRB_WIDTH);
  endfunction

  function automatic word_t merge_bytes(input word_t old, input word_t data, input strb_t strb);
    word_t res;
    res = old;
    for (int i = 0; i < `STRIPE_STRB_WIDTH; i++) begin
      if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
    errors++;
    $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
  endtask

  task automatic set_cfg(input int bank, input logic protect, input delay_t delay);
    cfg.strobe = 1'b1;
    cfg.bank = bank_sel_t'(bank);
    cfg.protect = protect;
    cfg.delay = delay;
    cfg_protect[bank] = protect;
    @(posedge axi_clk);
    #0.5ns;
    cfg.strobe = 1'b0;
  endtask

  task automatic send_aw(input int word);
    aw.addr.flat = byte_addr(word);
    awvalid = 1'b1;
    @(negedge axi_clk);
    while (!awready) @(negedge axi_clk);
    @(posedge axi_clk);
    #0.5ns;
    awvalid = 1'b0;
  endtask

  task automatic send_w(input word_t data, input strb_t strb);
    w.data = data;
    w.strb = strb;
    wvalid = 1'b1;
    @(negedge axi_clk);
    while (!wready) @(negedge axi_clk);
    @(posedge axi_clk);
    #0.5ns;
    wvalid = 1'b0;
  endtask

  // A positive w_lead sends W that many cycles ahead of AW, a negative one the reverse
  task automatic do_write(input int word, input word_t data, input strb_t strb, input int w_lead);
    int aw_wait;
    int w_wait;
    aw_wait = (w_lead > 0) ? w_lead : 0;
    w_wait = (w_lead < 0) ? -w_lead : 0;
    if (cfg_protect[word % `STRIPE_NUM_S]) begin
      exp_resp.push_back(slverr_code);
    end else begin
      exp_resp.push_back(okay_code);
      ref_mem[word] = merge_bytes(ref_mem[word], data, strb);
    end
    writes_issued++;
    fork
      begin
        repeat (aw_wait) @(posedge axi_clk);
        if (aw_wait > 0) #0.5ns;
        send_aw(word);
      end
      begin
        repeat (w_wait) @(posedge axi_clk);
        if (w_wait > 0) #0.5ns;
        send_w(data, strb);
      end
    join
  endtask

  task automatic wait_idle();
    while (exp_resp.size() != 0) @(negedge axi_clk);
    @(posedge axi_clk);
    #0.5ns;
  endtask

  task automatic check_read(input int word);
    rd_addr.flat = byte_addr(word);
    rd_en = 1'b1;
    @(posedge axi_clk);
    #0.5ns;
    rd_en = 1'b0;
    @(negedge axi_clk);
    checks++;
    if (!rd_valid) begin
      errors++;
      $display("No rd_valid one cycle after reading word %0d at %0t", word, $time);
    end else if (rd_data !== ref_mem[word]) begin
      report_mismatch("rd_data", ref_mem[word], rd_data);
    end
    @(posedge axi_clk);
    #0.5ns;
  endtask

  task automatic end_test(input string name);
    int delta;
    delta = total_errors() - test_start_errors;
    tests_run++;
    if (delta != 0) tests_failed++;
    $display("test %s: %s (%0d errors)", name, (delta == 0) ? "passed" : "failed", delta);
    test_start_errors = total_errors();
  endtask

  initial begin
    void'($urandom(32'h12b6));
    for (int i = 0; i < 32; i++) ref_mem[i] = '0;
    for (int i = 0; i < `STRIPE_NUM_S; i++) cfg_protect[i] = 1'b0;
    repeat (4) @(posedge axi_clk);
    #0.5ns;
    reset = 1'b0;
    @(posedge axi_clk);
    #0.5ns;

    for (int i = 0; i < 8; i++) do_write(i, word_t'($urandom), '1, 0);
    wait_idle();
    for (int i = 0; i < 8; i++) check_read(i);
    end_test("striping");

    do_write(9, word_t'($urandom), '1, 3);
    wait_idle();
    do_write(10, word_t'($urandom), '1, -3);
    wait_idle();
    check_read(9);
    check_read(10);
    end_test("aw_w_ordering");

    // The protected bank tags its response, so a swapped order shows up as a wrong code
    set_cfg(0, 1'b0, delay_t'(7));
    set_cfg(1, 1'b1, delay_t'(0));
    do_write(10, word_t'($urandom), '1, 0);
    do_write(11, word_t'($urandom), '1, 0);
    wait_idle();
    set_cfg(0, 1'b1, delay_t'(7));
    set_cfg(1, 1'b0, delay_t'(0));
    do_write(12, word_t'($urandom), '1, 0);
    do_write(13, word_t'($urandom), '1, 0);
    wait_idle();
    for (int i = 10; i < 14; i++) check_read(i);
    end_test("in_order_responses");

    set_cfg(0, 1'b0, delay_t'(0));
    set_cfg(1, 1'b0, delay_t'(0));
    do_write(14, word_t'($urandom), '1, 0);
    do_write(15, word_t'($urandom), '1, 0);
    wait_idle();
    set_cfg(0, 1'b1, delay_t'(0));
    do_write(14, word_t'($urandom), '1, 0);
    do_write(15, word_t'($urandom), '1, 0);
    wait_idle();
    check_read(14);
    check_read(15);
    set_cfg(0, 1'b0, delay_t'(0));
    end_test("protection");

    for (int i = 0; i < `STRIPE_NUM_S; i++) set_cfg(i, 1'b0, delay_t'($urandom_range(0, max_delay)));
    stall_bready = 1'b1;
    for (int i = 0; i < 12; i++) begin
      do_write(16 + $urandom_range(0, 7), word_t'($urandom),
               strb_t'($urandom_range(1, max_strb)), $urandom_range(0, 4) - 2);
    end
    wait_idle();
    stall_bready = 1'b0;
    checks++;
    if (b_count != writes_issued) begin
      errors++;
      $display("Saw %0d B responses for %0d writes", b_count, writes_issued);
    end
    for (int i = 16; i < 24; i++) check_read(i);
    end_test("backpressure_strobes");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, total_errors());
    if (total_errors() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== testbench/stripe_assert.sv ====
`include "stripe_macros.svh"

module stripe_assert (
  input logic                axi_clk,
  input logic                reset,
  input logic                awvalid,
  input logic                awready,
  input logic                wvalid,
  input logic                wready,
  input logic                bvalid,
  input logic                bready,
  input stripe_pkg::b_chan_t b,
  input logic                rd_en,
  input logic                rd_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  import stripe_pkg::*;

  int fail_count = 0;
  int aw_count;
  int w_count;
  int b_count;

  // Transfers seen on the manager port since reset
  always_ff @(posedge axi_clk) begin
    if (reset) begin
      aw_count <= 0;
      w_count  <= 0;
      b_count  <= 0;
    end else begin
      if (awvalid && awready) aw_count <= aw_count + 1;
      if (wvalid && wready) w_count <= w_count + 1;
      if (bvalid && bready) b_count <= b_count + 1;
    end
  end

  b_held: assert property (@(posedge axi_clk) disable iff (reset)
    bvalid && !bready |=> bvalid && $stable(b))
    else begin
      fail_count++;
      $error("bvalid dropped or the B payload changed before bready");
    end

  reset_quiet: assert property (@(posedge axi_clk)
    reset |=> !awready && !wready && !bvalid && !rd_valid)
    else begin
      fail_count++;
      $error("A ready or valid output was high right after reset");
    end

  rd_follows: assert property (@(posedge axi_clk) disable iff (reset)
    rd_en |=> rd_valid)
    else begin
      fail_count++;
      $error("rd_valid missing one cycle after rd_en");
    end

  rd_no_extra: assert property (@(posedge axi_clk) disable iff (reset)
    !rd_en |=> !rd_valid)
    else begin
      fail_count++;
      $error("rd_valid high without a read one cycle earlier");
    end

  // AW or W may run one ahead of the queue, never further
  outstanding: assert property (@(posedge axi_clk) disable iff (reset)
    (aw_count - b_count) <= `STRIPE_QUEUE_DEPTH && (w_count - b_count) <= `STRIPE_QUEUE_DEPTH)
    else begin
      fail_count++;
      $error("More writes outstanding than the response queue holds");
    end

endmodule

bind stripe_top stripe_assert stripe_assert_i (
  .axi_clk (axi_clk),
  .reset   (reset),
  .awvalid (awvalid),
  .awready (awready),
  .wvalid  (wvalid),
  .wready  (wready),
  .bvalid  (bvalid),
  .bready  (bready),
  .b       (b),
  .rd_en   (rd_en),
  .rd_valid(rd_valid)
);

// ==== source/stripe_top.sv ====
`include "stripe_macros.svh"

module stripe_top (
  input  logic                          axi_clk,
  input  logic                          reset,

  input  logic                          awvalid,
  output logic                          awready,
  input  stripe_pkg::aw_chan_t          aw,
  input  logic                          wvalid,
  output logic                          wready,
  input  stripe_pkg::w_chan_t           w,
  output logic                          bvalid,
  input  logic                          bready,
  output stripe_pkg::b_chan_t           b,

  input  stripe_pkg::cfg_write_t        cfg,

  input  logic                          rd_en,
  input  stripe_pkg::stripe_addr_u      rd_addr,
  output logic                          rd_valid,
  output logic [`STRIPE_DATA_WIDTH-1:0] rd_data
);
  import stripe_pkg::*;

  logic                                           req_awvalid;
  stripe_addr_u                                   req_addr;
  logic                                           req_accepted;
  logic                                           resp_accepted;
  bank_sel_t                                      req_sel;
  bank_sel_t                                      resp_sel;
  logic                                           req_active;
  logic                                           resp_active;

  logic [`STRIPE_NUM_S-1:0]                       bank_awvalid;
  logic [`STRIPE_NUM_S-1:0]                       bank_awready;
  logic [`STRIPE_NUM_S-1:0]                       bank_wvalid;
  logic [`STRIPE_NUM_S-1:0]                       bank_wready;
  logic [`STRIPE_NUM_S-1:0]                       bank_bvalid;
  logic [`STRIPE_NUM_S-1:0]                       bank_bready;
  aw_chan_t                                       bank_aw;
  w_chan_t                                        bank_w;
  b_chan_t [`STRIPE_NUM_S-1:0]                    bank_b;
  bank_cfg_t [`STRIPE_NUM_S-1:0]                  bank_cfg;
  logic [`STRIPE_NUM_S-1:0]                       bank_rd_en;
  logic [`STRIPE_NUM_S-1:0][`STRIPE_DATA_WIDTH-1:0] bank_rd_data;

  stripe_writer stripe_writer_i (
    .axi_clk      (axi_clk),
    .reset        (reset),
    .awvalid      (awvalid),
    .awready      (awready),
    .aw           (aw),
    .wvalid       (wvalid),
    .wready       (wready),
    .w            (w),
    .bvalid       (bvalid),
    .bready       (bready),
    .b            (b),
    .req_awvalid  (req_awvalid),
    .req_addr     (req_addr),
    .req_accepted (req_accepted),
    .resp_accepted(resp_accepted),
    .req_sel      (req_sel),
    .resp_sel     (resp_sel),
    .req_active   (req_active),
    .resp_active  (resp_active),
    .bank_awvalid (bank_awvalid),
    .bank_aw      (bank_aw),
    .bank_awready (bank_awready),
    .bank_wvalid  (bank_wvalid),
    .bank_w       (bank_w),
    .bank_wready  (bank_wready),
    .bank_bvalid  (bank_bvalid),
    .bank_bready  (bank_bready),
    .bank_b       (bank_b)
  );

  stripe_router stripe_router_i (
    .axi_clk      (axi_clk),
    .reset        (reset),
    .awvalid      (req_awvalid),
    .aw_addr      (req_addr),
    .req_accepted (req_accepted),
    .resp_accepted(resp_accepted),
    .req_sel      (req_sel),
    .resp_sel     (resp_sel),
    .req_active   (req_active),
    .resp_active  (resp_active),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .bank_rd_en   (bank_rd_en),
    .bank_rd_data (bank_rd_data),
    .rd_valid     (rd_valid),
    .rd_data      (rd_data)
  );

  stripe_config stripe_config_i (
    .axi_clk (axi_clk),
    .reset   (reset),
    .cfg     (cfg),
    .bank_cfg(bank_cfg)
  );

  for (genvar g = 0; g < `STRIPE_NUM_S; g++) begin : g_bank
    stripe_bank stripe_bank_i (
      .axi_clk(axi_clk),
      .reset  (reset),
      .awvalid(bank_awvalid[g]),
      .awready(bank_awready[g]),
      .aw     (bank_aw),
      .wvalid (bank_wvalid[g]),
      .wready (bank_wready[g]),
      .w      (bank_w),
      .bvalid (bank_bvalid[g]),
      .bready (bank_bready[g]),
      .b      (bank_b[g]),
      .cfg    (bank_cfg[g]),
      .rd_en  (bank_rd_en[g]),
      .rd_addr(rd_addr),
      .rd_data(bank_rd_data[g])
    );
  end

endmodule

// ==== source/stripe_writer.sv ====
`include "stripe_macros.svh"

module stripe_writer (
  input  logic                                        axi_clk,
  input  logic                                        reset,

  // Manager port
  input  logic                                        awvalid,
  output logic                                        awready,
  input  stripe_pkg::aw_chan_t                        aw,
  input  logic                                        wvalid,
  output logic                                        wready,
  input  stripe_pkg::w_chan_t                         w,
  output logic                                        bvalid,
  input  logic                                        bready,
  output stripe_pkg::b_chan_t                         b,

  // Router
  output logic                                        req_awvalid,
  output stripe_pkg::stripe_addr_u                    req_addr,
  output logic                                        req_accepted,
  output logic                                        resp_accepted,
  input  stripe_pkg::bank_sel_t                       req_sel,
  input  stripe_pkg::bank_sel_t                       resp_sel,
  input  logic                                        req_active,
  input  logic                                        resp_active,

  // Banks
  output logic [`STRIPE_NUM_S-1:0]                    bank_awvalid,
  output stripe_pkg::aw_chan_t                        bank_aw,
  input  logic [`STRIPE_NUM_S-1:0]                    bank_awready,
  output logic [`STRIPE_NUM_S-1:0]                    bank_wvalid,
  output stripe_pkg::w_chan_t                         bank_w,
  input  logic [`STRIPE_NUM_S-1:0]                    bank_wready,
  input  logic [`STRIPE_NUM_S-1:0]                    bank_bvalid,
  output logic [`STRIPE_NUM_S-1:0]                    bank_bready,
  input  stripe_pkg::b_chan_t [`STRIPE_NUM_S-1:0]     bank_b
);
  import stripe_pkg::*;

  logic                          awdone;
  logic                          wdone;
  logic                          aw_xfer;
  logic                          w_xfer;
  logic                          aw_have;
  logic                          w_have;
  logic [`STRIPE_ADDR_WIDTH-1:0] aw_addr_hold;
  w_chan_t                       w_hold;
  aw_chan_t                      aw_cur;
  w_chan_t                       w_cur;

  assign aw_xfer = awvalid && awready;
  assign w_xfer  = wvalid && wready;

  // Each half is remembered until the bank takes the pair
  always_ff @(posedge axi_clk) begin
    if (reset) begin
      awdone <= 1'b0;
      wdone  <= 1'b0;
    end else if (req_accepted) begin
      awdone <= 1'b0;
      wdone  <= 1'b0;
    end else begin
      if (aw_xfer) awdone <= 1'b1;
      if (w_xfer) wdone <= 1'b1;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (aw_xfer) aw_addr_hold <= aw.addr.flat;
    if (w_xfer) w_hold <= w;
  end

  // A half already taken comes from the hold register, otherwise straight from the port
  always_comb begin
    aw_cur.addr.flat = awdone ? aw_addr_hold : aw.addr.flat;
    w_cur            = wdone ? w_hold : w;
  end

  assign aw_have     = awdone || awvalid;
  assign w_have      = wdone || wvalid;

  assign req_awvalid = aw_have;
  assign req_addr    = aw_cur.addr;
  assign bank_aw     = aw_cur;
  assign bank_w      = w_cur;

  // The bank stores on the edge where it sees both halves while idle
  assign req_accepted  = req_active && aw_have && w_have &&
                         bank_awready[req_sel] && bank_wready[req_sel];
  assign resp_accepted = bvalid && bready;

  always_comb begin
    bank_awvalid = '0;
    bank_wvalid  = '0;
    bank_bready  = '0;
    awready      = 1'b0;
    wready       = 1'b0;
    bvalid       = 1'b0;
    b            = '0;

    if (req_active) begin
      bank_awvalid[req_sel] = aw_have;
      bank_wvalid[req_sel]  = w_have;
      awready               = !awdone && bank_awready[req_sel];
      wready                = !wdone && bank_wready[req_sel];
    end

    // Only the oldest outstanding bank may answer
    if (resp_active) begin
      bank_bready[resp_sel] = bready;
      bvalid                = bank_bvalid[resp_sel];
      b                     = bank_b[resp_sel];
    end
  end

endmodule

// ==== source/stripe_router.sv ====
`include "stripe_macros.svh"

module stripe_router (
  input  logic                                           axi_clk,
  input  logic                                           reset,

  input  logic                                           awvalid,
  input  stripe_pkg::stripe_addr_u                       aw_addr,
  input  logic                                           req_accepted,
  input  logic                                           resp_accepted,
  output stripe_pkg::bank_sel_t                          req_sel,
  output stripe_pkg::bank_sel_t                          resp_sel,
  output logic                                           req_active,
  output logic                                           resp_active,

  input  logic                                           rd_en,
  input  stripe_pkg::stripe_addr_u                       rd_addr,
  output logic [`STRIPE_NUM_S-1:0]                       bank_rd_en,
  input  logic [`STRIPE_NUM_S-1:0][`STRIPE_DATA_WIDTH-1:0] bank_rd_data,
  output logic                                           rd_valid,
  output logic [`STRIPE_DATA_WIDTH-1:0]                  rd_data
);
  import stripe_pkg::*;

  localparam int depth = `STRIPE_QUEUE_DEPTH;
  localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_bits = $clog2(depth + 1);

  bank_sel_t             queue [depth];
  logic [ptr_bits-1:0]   head;
  logic [ptr_bits-1:0]   tail;
  logic [count_bits-1:0] count;
  bank_sel_t             rd_sel;

  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
    return (ptr == ptr_bits'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // With no address on offer the request side points at bank 0
  assign req_sel     = awvalid ? aw_addr.fields.bank : '0;
  assign req_active  = count != count_bits'(depth);
  assign resp_active = count != '0;
  assign resp_sel    = queue[head];

  // Banks in acceptance order, so B can be returned in that order
  always_ff @(posedge axi_clk) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (req_accepted) tail <= next_ptr(tail);
      if (resp_accepted) head <= next_ptr(head);
      case ({req_accepted, resp_accepted})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge axi_clk) begin
    if (req_accepted) queue[tail] <= req_sel;
  end

  always_comb begin
    bank_rd_en = '0;
    bank_rd_en[rd_addr.fields.bank] = rd_en;
  end

  always_ff @(posedge axi_clk) begin
    if (reset) rd_valid <= 1'b0;
    else rd_valid <= rd_en;
  end

  // The bank registers its word, so only the index is kept here for the return mux
  always_ff @(posedge axi_clk) begin
    if (rd_en) rd_sel <= rd_addr.fields.bank;
  end

  assign rd_data = bank_rd_data[rd_sel];

endmodule

// ==== source/stripe_bank.sv ====
`include "stripe_macros.svh"

module stripe_bank (
  input  logic                          axi_clk,
  input  logic                          reset,

  input  logic                          awvalid,
  output logic                          awready,
  input  stripe_pkg::aw_chan_t          aw,
  input  logic                          wvalid,
  output logic                          wready,
  input  stripe_pkg::w_chan_t           w,
  output logic                          bvalid,
  input  logic                          bready,
  output stripe_pkg::b_chan_t           b,

  input  stripe_pkg::bank_cfg_t         cfg,

  input  logic                          rd_en,
  input  stripe_pkg::stripe_addr_u      rd_addr,
  output logic [`STRIPE_DATA_WIDTH-1:0] rd_data
);
  import stripe_pkg::*;

  localparam int rows = 2 ** row_bits;

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_wait = 2'd1;
  localparam logic [1:0] st_resp = 2'd2;

  logic [1:0]                     state;
  logic [1:0]                     state_next;
  logic                           ready;
  logic                           accept;
  logic [`STRIPE_DELAY_WIDTH-1:0] count;
  logic [`STRIPE_DATA_WIDTH-1:0]  mem [rows];

  // Ready is registered so it stays low in the first cycle out of reset
  assign awready = ready;
  assign wready  = ready;
  assign accept  = awvalid && wvalid && ready;
  assign bvalid  = state == st_resp;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (accept) state_next = st_wait;
      st_wait: if (count == '0) state_next = st_resp;
      st_resp: if (bready) state_next = st_idle;
      default: state_next = st_idle;
    endcase
  end

  // The delay is sampled on acceptance, so bvalid rises delay+1 cycles later
  always_ff @(posedge axi_clk) begin
    if (reset) begin
      state <= st_idle;
      ready <= 1'b0;
      count <= '0;
    end else begin
      state <= state_next;
      ready <= state_next == st_idle;
      if (accept) count <= cfg.delay;
      else if (state == st_wait && count != '0) count <= count - 1'b1;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (accept) b <= b_chan_t'{resp: cfg.protect ? resp_slverr : resp_okay};
  end

  // A protected bank still answers but leaves its memory alone
  always_ff @(posedge axi_clk) begin
    if (reset) begin
      for (int r = 0; r < rows; r++) mem[r] <= '0;
    end else if (accept && !cfg.protect) begin
      for (int i = 0; i < `STRIPE_STRB_WIDTH; i++) begin
        if (w.strb[i]) mem[aw.addr.fields.row][8*i +: 8] <= w.data[8*i +: 8];
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (rd_en) rd_data <= mem[rd_addr.fields.row];
  end

endmodule

// ==== source/stripe_config.sv ====
`include "stripe_macros.svh"

module stripe_config (
  input  logic                                      axi_clk,
  input  logic                                      reset,
  input  stripe_pkg::cfg_write_t                    cfg,
  output stripe_pkg::bank_cfg_t [`STRIPE_NUM_S-1:0] bank_cfg
);
  import stripe_pkg::*;

  // One register per bank. A strobe only loads the bank it names
  for (genvar g = 0; g < `STRIPE_NUM_S; g++) begin : g_cfg
    logic hit;

    assign hit = cfg.strobe && (cfg.bank == bank_sel_t'(g));

    always_ff @(posedge axi_clk) begin
      if (reset) begin
        bank_cfg[g] <= bank_cfg_t'{protect: 1'b0, delay: '0};
      end else if (hit) begin
        bank_cfg[g] <= bank_cfg_t'{protect: cfg.protect, delay: cfg.delay};
      end
    end
  end

endmodule

// ==== source/stripe_pkg.sv ====
`include "stripe_macros.svh"

package stripe_pkg;

  // From the bottom up, an address is byte offset, bank index, then row
  localparam int offset_bits = $clog2(`STRIPE_STRB_WIDTH);
  localparam int sel_bits = $clog2(`STRIPE_NUM_S);
  localparam int row_bits = `STRIPE_ADDR_WIDTH - sel_bits - offset_bits;

  typedef logic [sel_bits-1:0] bank_sel_t;

  typedef struct packed {
    logic [row_bits-1:0]    row;
    bank_sel_t              bank;
    logic [offset_bits-1:0] offset;
  } stripe_addr_fields_t;

  // Consecutive words land on consecutive banks because bank sits right above the offset
  typedef union packed {
    logic [`STRIPE_ADDR_WIDTH-1:0] flat;
    stripe_addr_fields_t           fields;
  } stripe_addr_u;

  typedef struct packed {
    stripe_addr_u addr;
  } aw_chan_t;

  typedef struct packed {
    logic [`STRIPE_DATA_WIDTH-1:0] data;
    logic [`STRIPE_STRB_WIDTH-1:0] strb;
  } w_chan_t;

  typedef struct packed {
    logic [1:0] resp;
  } b_chan_t;

  typedef struct packed {
    logic                           protect;
    logic [`STRIPE_DELAY_WIDTH-1:0] delay;
  } bank_cfg_t;

  typedef struct packed {
    logic                           strobe;
    bank_sel_t                      bank;
    logic                           protect;
    logic [`STRIPE_DELAY_WIDTH-1:0] delay;
  } cfg_write_t;

  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// ==== source/stripe_macros.svh ====
`ifndef STRIPE_MACROS_SVH
`define STRIPE_MACROS_SVH

// Number of word banks. Must be a power of two and at least two
`define STRIPE_NUM_S 2

// Byte address width of the manager port
`define STRIPE_ADDR_WIDTH 20

// Data word width and its byte strobe
`define STRIPE_DATA_WIDTH 16
`define STRIPE_STRB_WIDTH ((`STRIPE_DATA_WIDTH + 7) / 8)

// Writes that may be in flight at once
`define STRIPE_QUEUE_DEPTH 2

// A 3-bit field gives a response delay of 0 to 7 cycles
`define STRIPE_DELAY_WIDTH 3

`endif
